// File: common/mdu_config.svh
`ifndef MDU_CONFIG_SVH
`define MDU_CONFIG_SVH

// datapath width.
`define MDU_XLEN 32

// width of the decode tag carried alongside an operation.
`define MDU_TAG_W 8

// opcode field width.
`define MDU_OP_W 3

// multiplier latency from acceptance to valid_o.
`define MDU_MUL_LAT 2

// divider latency: load, one iteration per bit, fixup.
`define MDU_DIV_LAT 34

`endif

// File: common/mdu_pkg.sv
`include "mdu_config.svh"

package mdu_pkg;

    // operand / result word.
    typedef logic [`MDU_XLEN-1:0] word_t;

    // one bit wider than a word, for sign extension and partial remainders.
    typedef logic [`MDU_XLEN:0] word_ext_t;

    // opaque decode info travelling with the request.
    typedef logic [`MDU_TAG_W-1:0] mdu_tag_t;

    typedef enum logic [`MDU_OP_W-1:0] {
        MDU_MUL   = 3'd0,
        MDU_MULH  = 3'd1,
        MDU_MULHU = 3'd2,
        MDU_DIV   = 3'd3,
        MDU_DIVU  = 3'd4,
        MDU_MOD   = 3'd5,
        MDU_MODU  = 3'd6
    } mdu_op_e;

    // divider sequencer.
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_ITER = 2'd1,
        DIV_FIX  = 2'd2,
        DIV_DONE = 2'd3
    } div_state_e;

    // true for the ops that go to the multiplier.
    function automatic logic op_is_mul(input mdu_op_e op);
        return (op == MDU_MUL) || (op == MDU_MULH) || (op == MDU_MULHU);
    endfunction

endpackage

// File: mdu/mdu_muler.sv
`timescale 1ns/1ps
`include "mdu_config.svh"

module mdu_muler import mdu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    flush_i,

    input  mdu_op_e op_i,
    input  word_t   src_a_i,
    input  word_t   src_b_i,
    input  logic    valid_i,
    output logic    ready_o,

    output word_t   result_o,
    output logic    valid_o,
    input  logic    ready_i
);

    logic      sign_ext;
    logic      take_high;
    word_ext_t a_ext, b_ext;

    word_ext_t a_s1_q, b_s1_q;
    logic      high_s1_q;
    logic      s1_valid_q;
    logic      advance;

    logic signed [2*`MDU_XLEN+1:0] prod;
    word_t     result_q;

    // only MULHU treats the operands as unsigned.
    assign sign_ext  = (op_i != MDU_MULHU);
    assign take_high = (op_i != MDU_MUL);
    assign a_ext     = {sign_ext & src_a_i[`MDU_XLEN-1], src_a_i};
    assign b_ext     = {sign_ext & src_b_i[`MDU_XLEN-1], src_b_i};

    assign ready_o = ~s1_valid_q & ~valid_o;
    assign advance = s1_valid_q & (~valid_o | ready_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            valid_o    <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;
            valid_o    <= 1'b0;
        end else begin
            if (valid_i && ready_o) begin
                s1_valid_q <= 1'b1;
            end else if (advance) begin
                s1_valid_q <= 1'b0;
            end

            if (advance) begin
                valid_o <= 1'b1;
            end else if (ready_i) begin
                valid_o <= 1'b0; // consumed.
            end
        end
    end

    // stage one: extended operands and half select.
    always_ff @(posedge clk) begin
        if (valid_i && ready_o) begin
            a_s1_q    <= a_ext;
            b_s1_q    <= b_ext;
            high_s1_q <= take_high;
        end
    end

    assign prod = $signed(a_s1_q) * $signed(b_s1_q);

    // stage two: product half, held until read.
    always_ff @(posedge clk) begin
        if (advance) begin
            result_q <= high_s1_q ? prod[2*`MDU_XLEN-1:`MDU_XLEN]
                                  : prod[`MDU_XLEN-1:0];
        end
    end

    assign result_o = result_q;

    a_result_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (valid_o && !ready_i) |=> $stable(result_o));

endmodule

// File: mdu/mdu_diver.sv
`timescale 1ns/1ps
`include "mdu_config.svh"

module mdu_diver import mdu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    flush_i,

    input  mdu_op_e op_i,
    input  word_t   src_a_i,
    input  word_t   src_b_i,
    input  logic    valid_i,
    output logic    ready_o,

    output word_t   result_o,
    output logic    valid_o,
    input  logic    ready_i
);

    // load and fixup take one cycle each.
    localparam int ITERS = `MDU_DIV_LAT - 2;
    localparam int CNT_W = $clog2(ITERS);

    div_state_e       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             accept;

    logic  is_signed, is_rem;
    logic  a_neg, b_neg;
    word_t abs_a, abs_b;

    word_t quo_q, rem_q, dvs_q, dvd_q, result_q;
    logic  q_neg_q, r_neg_q, is_rem_q, dvs_zero_q, ovf_q;

    word_ext_t             shifted;
    logic [`MDU_XLEN+1:0]  trial;
    logic                  fits;
    word_t                 quo_fix, rem_fix;

    assign ready_o = (state_q == DIV_IDLE);
    assign valid_o = (state_q == DIV_DONE);
    assign accept  = valid_i & ready_o;

    assign is_signed = (op_i == MDU_DIV) || (op_i == MDU_MOD);
    assign is_rem    = (op_i == MDU_MOD) || (op_i == MDU_MODU);
    assign a_neg     = is_signed & src_a_i[`MDU_XLEN-1];
    assign b_neg     = is_signed & src_b_i[`MDU_XLEN-1];
    assign abs_a     = a_neg ? (~src_a_i + 1'b1) : src_a_i;
    assign abs_b     = b_neg ? (~src_b_i + 1'b1) : src_b_i;

    // restoring step on magnitudes.
    assign shifted = {rem_q, quo_q[`MDU_XLEN-1]};
    assign trial   = {1'b0, shifted} - {2'b00, dvs_q};
    assign fits    = ~trial[`MDU_XLEN+1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else if (flush_i) begin
            state_q <= DIV_IDLE;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (accept) begin
                        state_q <= DIV_ITER;
                        cnt_q   <= CNT_W'(ITERS - 1);
                    end
                end
                DIV_ITER: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == '0) begin
                        state_q <= DIV_FIX;
                    end
                end
                DIV_FIX:  state_q <= DIV_DONE;
                DIV_DONE: begin
                    if (ready_i) begin
                        state_q <= DIV_IDLE;
                    end
                end
                default:  state_q <= DIV_IDLE;
            endcase
        end
    end

    // signs, zero divisor and overflow are resolved here.
    always_comb begin
        quo_fix = q_neg_q ? (~quo_q + 1'b1) : quo_q;
        rem_fix = r_neg_q ? (~rem_q + 1'b1) : rem_q;
        if (dvs_zero_q) begin
            quo_fix = '1;
            rem_fix = dvd_q;
        end else if (ovf_q) begin
            quo_fix = dvd_q;
            rem_fix = '0;
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            DIV_IDLE: begin
                if (accept) begin
                    quo_q      <= abs_a; // dividend shifts out of the top.
                    rem_q      <= '0;
                    dvs_q      <= abs_b;
                    dvd_q      <= src_a_i;
                    q_neg_q    <= a_neg ^ b_neg;
                    r_neg_q    <= a_neg;
                    is_rem_q   <= is_rem;
                    dvs_zero_q <= (src_b_i == '0);
                    ovf_q      <= is_signed && (src_a_i == {1'b1, {(`MDU_XLEN-1){1'b0}}})
                                  && (src_b_i == '1);
                end
            end
            DIV_ITER: begin
                rem_q <= fits ? trial[`MDU_XLEN-1:0] : shifted[`MDU_XLEN-1:0];
                quo_q <= {quo_q[`MDU_XLEN-2:0], fits};
            end
            DIV_FIX: begin
                result_q <= is_rem_q ? rem_fix : quo_fix;
            end
            default: begin
            end
        endcase
    end

    assign result_o = result_q;

    // a result only follows the fixup cycle.
    a_valid_after_fix: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(valid_o) |-> $past(state_q) == DIV_FIX);

    a_flush_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> state_q == DIV_IDLE);

endmodule

// File: mdu/mdu.sv
`timescale 1ns/1ps
`include "mdu_config.svh"

module mdu import mdu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     flush_i,

    input  mdu_op_e  op_i,
    input  word_t    src_a_i,
    input  word_t    src_b_i,
    input  mdu_tag_t tag_i,
    input  logic     valid_i,
    output logic     ready_o,

    output word_t    result_o,
    output mdu_tag_t tag_o,
    output logic     valid_o,
    input  logic     ready_i
);

    logic     accept;
    logic     is_mul;
    logic     held_mul;
    logic     busy_q;
    mdu_op_e  op_q;
    mdu_tag_t tag_q;

    logic     mul_valid, div_valid;
    logic     mul_ready, div_ready;
    logic     mul_valid_o, div_valid_o;
    word_t    mul_result, div_result;

    // one operation in flight, and nothing new while the sink stalls.
    assign ready_o = ~busy_q & ready_i;
    assign accept  = valid_i & ready_o;

    assign is_mul    = op_is_mul(op_i);
    assign mul_valid = accept & is_mul;
    assign div_valid = accept & ~is_mul;

    mdu_muler mdu_muler_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .op_i     (op_i),
        .src_a_i  (src_a_i),
        .src_b_i  (src_b_i),
        .valid_i  (mul_valid),
        .ready_o  (mul_ready),
        .result_o (mul_result),
        .valid_o  (mul_valid_o),
        .ready_i  (ready_i)
    );

    mdu_diver mdu_diver_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .op_i     (op_i),
        .src_a_i  (src_a_i),
        .src_b_i  (src_b_i),
        .valid_i  (div_valid),
        .ready_o  (div_ready),
        .result_o (div_result),
        .valid_o  (div_valid_o),
        .ready_i  (ready_i)
    );

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            op_q   <= MDU_MUL;
        end else if (flush_i) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
            op_q   <= op_i;
        end else if (valid_o && ready_i) begin
            busy_q <= 1'b0; // result handed off.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_q <= tag_i;
        end
    end

    assign held_mul = op_is_mul(op_q);
    assign result_o = held_mul ? mul_result : div_result;
    assign valid_o  = held_mul ? mul_valid_o : div_valid_o;
    assign tag_o    = tag_q;

    // a unit holding a result must block new requests.
    a_no_accept_pending: assert property (@(posedge clk) disable iff (!rst_n_i)
        (mul_valid_o || div_valid_o) |-> !accept);

    a_tag_stable: assert property (@(posedge clk) disable iff (!rst_n_i || flush_i)
        (valid_o && !ready_i) |=> $stable(tag_o));

    // the busy flag keeps the steered unit free.
    a_unit_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!mul_valid || mul_ready) && (!div_valid || div_ready));

    a_mul_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(mul_valid_o) |-> $past(mul_valid, `MDU_MUL_LAT));

endmodule

// File: source/mdu_top.sv
`timescale 1ns/1ps
`include "mdu_config.svh"

module mdu_top import mdu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     flush_i,

    // request side.
    input  mdu_op_e  op_i,
    input  word_t    src_a_i,
    input  word_t    src_b_i,
    input  mdu_tag_t tag_i,
    input  logic     valid_i,
    output logic     ready_o,

    // result side.
    output word_t    result_o,
    output mdu_tag_t tag_o,
    output logic     valid_o,
    input  logic     ready_i
);

    mdu mdu_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .op_i     (op_i),
        .src_a_i  (src_a_i),
        .src_b_i  (src_b_i),
        .tag_i    (tag_i),
        .valid_i  (valid_i),
        .ready_o  (ready_o),
        .result_o (result_o),
        .tag_o    (tag_o),
        .valid_o  (valid_o),
        .ready_i  (ready_i)
    );

endmodule

// File: verification/mdu_tb.sv
`timescale 1ns/1ps
`include "mdu_config.svh"

module mdu_tb import mdu_pkg::*; ();

    localparam int          ACCEPT_LIMIT = 100;
    localparam int          RESULT_LIMIT = `MDU_DIV_LAT + 200;
    localparam int          RANDOM_OPS   = 60;
    localparam logic [31:0] LFSR_SEED    = 32'ha678_2f19;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
    localparam word_t       MOST_NEG     = {1'b1, {(`MDU_XLEN-1){1'b0}}};

    logic     clk;
    logic     rst_n_i;
    logic     flush_i;
    mdu_op_e  op_i;
    word_t    src_a_i, src_b_i;
    mdu_tag_t tag_i;
    logic     valid_i, ready_o;
    word_t    result_o;
    mdu_tag_t tag_o;
    logic     valid_o, ready_i;

    logic [31:0] lfsr_state = LFSR_SEED;
    logic        stall_en = 1'b0; // random back-pressure on the sink.

    // scoreboard entries in acceptance order.
    word_t    exp_result_q[$];
    mdu_tag_t exp_tag_q[$];
    int       exp_lat_q[$];
    int       acc_cyc_q[$];

    word_t    head_result = '0;
    mdu_tag_t head_tag = '0;
    int       head_lat = 0;
    int       head_acc_cyc = 0;
    int       sb_count = 0;
    int       cyc = 0;
    word_t    prev_result;
    mdu_tag_t prev_tag;
    int       accepted = 0;
    int       transferred = 0;
    int       flushed = 0;

    mdu_top mdu_top_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .op_i     (op_i),
        .src_a_i  (src_a_i),
        .src_b_i  (src_b_i),
        .tag_i    (tag_i),
        .valid_i  (valid_i),
        .ready_o  (ready_o),
        .result_o (result_o),
        .tag_o    (tag_o),
        .valid_o  (valid_o),
        .ready_i  (ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        fail_run($sformatf("mismatch %s expected 0x%h got 0x%h", sig, exp, act));
    endtask

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
        end
        return v;
    endfunction

    // one in four operands is a corner value.
    function automatic word_t pick_operand();
        logic [1:0] sel;
        sel = 2'(rand_bits(2));
        if (sel != 2'd0) return rand_bits(`MDU_XLEN);
        case (rand_bits(2))
            2'd0:    return '0;
            2'd1:    return '1;
            2'd2:    return MOST_NEG;
            default: return ~MOST_NEG;
        endcase
    endfunction

    function automatic mdu_op_e pick_op();
        logic [2:0] v;
        v = 3'(rand_bits(3));
        return (v == 3'd7) ? MDU_DIV : mdu_op_e'(v);
    endfunction

    function automatic int op_latency(input mdu_op_e op);
        if (op == MDU_MUL || op == MDU_MULH || op == MDU_MULHU) return `MDU_MUL_LAT;
        return `MDU_DIV_LAT;
    endfunction

    function automatic word_t model_result(input mdu_op_e op, input word_t a, input word_t b);
        logic signed [2*`MDU_XLEN-1:0] sprod;
        logic [2*`MDU_XLEN-1:0]        uprod;
        logic                          ovf;
        sprod = $signed({{`MDU_XLEN{a[`MDU_XLEN-1]}}, a})
              * $signed({{`MDU_XLEN{b[`MDU_XLEN-1]}}, b});
        uprod = {{`MDU_XLEN{1'b0}}, a} * {{`MDU_XLEN{1'b0}}, b};
        ovf   = (a == MOST_NEG) && (b == '1);
        case (op)
            MDU_MUL:   return uprod[`MDU_XLEN-1:0];
            MDU_MULH:  return sprod[2*`MDU_XLEN-1:`MDU_XLEN];
            MDU_MULHU: return uprod[2*`MDU_XLEN-1:`MDU_XLEN];
            MDU_DIV: begin
                if (b == '0) return '1;
                if (ovf) return a;
                return $signed(a) / $signed(b); // truncates toward zero.
            end
            MDU_DIVU: return (b == '0) ? '1 : a / b;
            MDU_MOD: begin
                if (b == '0) return a;
                if (ovf) return '0;
                return $signed(a) % $signed(b);
            end
            MDU_MODU: return (b == '0) ? a : a % b;
            default:  return '0;
        endcase
    endfunction

    always @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            flushed += exp_result_q.size(); // a killed operation never returns.
            exp_result_q.delete();
            exp_tag_q.delete();
            exp_lat_q.delete();
            acc_cyc_q.delete();
        end else begin
            if (valid_o && ready_i) begin
                transferred++; // every output transfer, expected or not.
                if (exp_result_q.size() != 0) begin
                    exp_result_q.delete(0);
                    exp_tag_q.delete(0);
                    exp_lat_q.delete(0);
                    acc_cyc_q.delete(0);
                end
            end
            if (valid_i && ready_o) begin
                exp_result_q.push_back(model_result(op_i, src_a_i, src_b_i));
                exp_tag_q.push_back(tag_i);
                exp_lat_q.push_back(op_latency(op_i));
                acc_cyc_q.push_back(cyc);
                accepted++;
            end
        end
        sb_count <= exp_result_q.size();
        if (exp_result_q.size() != 0) begin
            head_result  <= exp_result_q[0];
            head_tag     <= exp_tag_q[0];
            head_lat     <= exp_lat_q[0];
            head_acc_cyc <= acc_cyc_q[0];
        end
        cyc         <= cyc + 1;
        prev_result <= result_o;
        prev_tag    <= tag_o;
    end

    a_result: assert property (@(posedge clk) disable iff (!rst_n_i)
        (valid_o && sb_count != 0) |-> result_o == head_result)
        else report_mismatch("result_o", $sampled(head_result), $sampled(result_o));
    a_tag: assert property (@(posedge clk) disable iff (!rst_n_i)
        (valid_o && sb_count != 0) |-> tag_o == head_tag)
        else report_mismatch("tag_o", $sampled(head_tag), $sampled(tag_o));
    a_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(valid_o) |-> (cyc - head_acc_cyc) == head_lat)
        else report_mismatch("valid_o latency", $sampled(head_lat),
                             $sampled(cyc - head_acc_cyc));
    a_no_orphan: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_o |-> sb_count != 0)
        else fail_run("valid_o is high with no operation in flight");
    a_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        sb_count != 0 |-> !ready_o)
        else fail_run("ready_o is high while an operation is in flight");
    a_idle_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        sb_count == 0 |-> ready_o == ready_i)
        else report_mismatch("ready_o", $sampled(ready_i), $sampled(ready_o));
    a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n_i || flush_i)
        (valid_o && !ready_i) |=> valid_o)
        else fail_run("valid_o dropped before the result was taken");
    a_hold_result: assert property (@(posedge clk) disable iff (!rst_n_i || flush_i)
        (valid_o && !ready_i) |=> result_o == prev_result)
        else report_mismatch("result_o", $sampled(prev_result), $sampled(result_o));
    a_hold_tag: assert property (@(posedge clk) disable iff (!rst_n_i || flush_i)
        (valid_o && !ready_i) |=> tag_o == prev_tag)
        else report_mismatch("tag_o", $sampled(prev_tag), $sampled(tag_o));

    task automatic next_cycle();
        @(posedge clk);
        ready_i <= stall_en ? (rand_bits(1) != 0) : 1'b1;
    endtask

    task automatic send_request(input mdu_op_e op, input word_t a, input word_t b);
        int   t;
        logic taken;
        op_i    <= op;
        src_a_i <= a;
        src_b_i <= b;
        tag_i   <= mdu_tag_t'(rand_bits(`MDU_TAG_W));
        valid_i <= 1'b1;
        t = 0;
        taken = 1'b0;
        while (!taken && t < ACCEPT_LIMIT) begin
            next_cycle();
            t++;
            taken = valid_i && ready_o;
        end
        if (!taken) fail_run("request was not accepted before the timeout");
        valid_i <= 1'b0;
    endtask

    task automatic wait_result();
        int   t;
        logic taken;
        t = 0;
        taken = 1'b0;
        while (!taken && t < RESULT_LIMIT) begin
            next_cycle();
            t++;
            taken = valid_o && ready_i;
        end
        if (!taken) fail_run("no result was returned before the timeout");
    endtask

    task automatic run_op(input mdu_op_e op, input word_t a, input word_t b);
        send_request(op, a, b);
        wait_result();
    endtask

    // kill the operation some cycles after acceptance and watch for a late result.
    task automatic flush_op(input mdu_op_e op, input word_t a, input word_t b, input int delay);
        send_request(op, a, b);
        repeat (delay) next_cycle();
        flush_i <= 1'b1;
        next_cycle();
        flush_i <= 1'b0;
        repeat (`MDU_DIV_LAT + 4) next_cycle();
    endtask

    initial begin
        mdu_op_e op;
        word_t   a, b;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        op_i    = MDU_MUL;
        src_a_i = '0;
        src_b_i = '0;
        tag_i   = '0;
        valid_i = 1'b0;
        ready_i = 1'b1;
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;

        stall_en = 1'b1; // ready_o must track ready_i while idle.
        repeat (8) next_cycle();
        stall_en = 1'b0;

        run_op(MDU_MUL, '1, '1);
        run_op(MDU_MULH, MOST_NEG, MOST_NEG);
        run_op(MDU_MULHU, '1, '1);
        run_op(MDU_MULH, MOST_NEG, '1);
        run_op(MDU_MUL, '0, 32'h1234_5678);
        run_op(MDU_DIV, -32'sd7, 32'd2);
        run_op(MDU_MOD, -32'sd7, 32'd2);
        run_op(MDU_DIV, 32'd7, -32'sd2);
        run_op(MDU_MOD, 32'd7, -32'sd2);
        run_op(MDU_DIV, -32'sd7, -32'sd2);
        run_op(MDU_DIVU, '1, 32'd2);
        run_op(MDU_MODU, '1, 32'd10);
        run_op(MDU_DIV, 32'h1234_5678, '0);
        run_op(MDU_DIVU, 32'h1234_5678, '0);
        run_op(MDU_MOD, MOST_NEG, '0);
        run_op(MDU_MODU, 32'h1234_5678, '0);
        run_op(MDU_DIV, MOST_NEG, '1);
        run_op(MDU_MOD, MOST_NEG, '1);
        run_op(MDU_DIVU, MOST_NEG, '1);

        for (int pass = 0; pass < 2; pass++) begin
            stall_en = (pass == 1);
            for (int n = 0; n < RANDOM_OPS; n++) begin
                op = pick_op();
                a  = pick_operand();
                b  = pick_operand();
                run_op(op, a, b);
            end
        end
        stall_en = 1'b0;

        flush_op(MDU_MULH, 32'hdead_beef, 32'h0bad_f00d, 0);
        run_op(MDU_MULHU, 32'hdead_beef, 32'h0bad_f00d);
        flush_op(MDU_DIV, 32'h8765_4321, 32'd3, 10);
        run_op(MDU_MOD, 32'h8765_4321, 32'd3);

        repeat (5) next_cycle();
        if (exp_result_q.size() != 0 || accepted != transferred + flushed) begin
            fail_run($sformatf("request count is off: %0d accepted, %0d returned, %0d flushed",
                               accepted, transferred, flushed));
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: vlog.f
+incdir+common
common/mdu_pkg.sv
mdu/mdu_muler.sv
mdu/mdu_diver.sv
mdu/mdu.sv
source/mdu_top.sv
verification/mdu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mdu_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG  := Test passed

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+')
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the run passes only if the testbench printed the pass message.
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
